// File: cpu_isa_pkg.sv
// MIPS-like ISA encodings
`default_nettype none

package cpu_isa_pkg;

	// ------------------------------------------------------------------------
	//  widths
	// ------------------------------------------------------------------------
	localparam int XLEN       = 32;
	localparam int REG_ADDR_W = 5;
	localparam int SHAMT_W    = 5;
	localparam int BYTE_LANES = 4;
	localparam int INDEX_W    = 26;

	// ------------------------------------------------------------------------
	//  function codes
	// ------------------------------------------------------------------------
	typedef enum logic [1:0] {
		ADDER_ADD = 2'b00,
		ADDER_SUB = 2'b01
	} adder_func_e;

	typedef enum logic [1:0] {
		LOGIC_AND = 2'b00,
		LOGIC_OR  = 2'b01,
		LOGIC_XOR = 2'b10,
		LOGIC_NOR = 2'b11
	} logic_func_e;

	typedef enum logic {
		COMP_SLT  = 1'b0,
		COMP_SLTU = 1'b1
	} comp_func_e;

	typedef enum logic [1:0] {
		SHIFT_SLL = 2'b00,
		SHIFT_SRL = 2'b10,
		SHIFT_SRA = 2'b11
	} shift_func_e;

	// jumps and branches, codes as in the decoder
	typedef enum logic [3:0] {
		BR_JALR = 4'b0000,
		BR_BLTZ = 4'b0001,
		BR_J    = 4'b0010,
		BR_JAL  = 4'b0011,
		BR_BEQ  = 4'b0100,
		BR_BNE  = 4'b0101,
		BR_BLEZ = 4'b0110,
		BR_BGTZ = 4'b0111,
		BR_BGEZ = 4'b1001
	} branch_func_e;

	typedef enum logic [1:0] {
		SIZE_BYTE = 2'b00,
		SIZE_HALF = 2'b01,
		SIZE_WORD = 2'b10
	} mem_size_e;

endpackage

`default_nettype wire

// File: ex_stage_pkg.sv
// execution stage packets
`default_nettype none

package ex_stage_pkg;

	// destination source select, at most one set
	typedef struct packed {
		logic alu;
		logic shifter;
		logic pc;
	} dst_src_t;

	// ------------------------------------------------------------------------
	//  decoded op into the stage
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic                                   adder_en;
		cpu_isa_pkg::adder_func_e               adder_func;
		logic                                   logic_en;
		cpu_isa_pkg::logic_func_e               logic_func;
		logic                                   comp_en;
		cpu_isa_pkg::comp_func_e                comp_func;
		logic                                   alu_imm_en;
		logic [cpu_isa_pkg::XLEN-1:0]           imm;
		logic                                   shifter_en;
		cpu_isa_pkg::shift_func_e               shift_func;
		logic                                   sa_en;
		logic [cpu_isa_pkg::SHAMT_W-1:0]        sa_data;
		logic                                   branch_en;
		cpu_isa_pkg::branch_func_e              branch_func;
		logic [cpu_isa_pkg::INDEX_W-1:0]        index;
		logic                                   index_en;
		logic                                   imm_en;
		logic                                   rs_en;
		logic                                   mem_en;
		logic                                   mem_we;
		cpu_isa_pkg::mem_size_e                 mem_size;
		logic                                   dst_reg_en;
		logic [cpu_isa_pkg::REG_ADDR_W-1:0]     dst_reg_addr;
		dst_src_t                               dst_src;
	} ex_op_t;

	typedef struct packed {
		logic zero;
		logic negative;
	} alu_flags_t;

	// ------------------------------------------------------------------------
	//  results out of the stage
	// ------------------------------------------------------------------------
	typedef struct packed {
		logic                                   en;
		logic [cpu_isa_pkg::REG_ADDR_W-1:0]     addr;
		logic [cpu_isa_pkg::XLEN-1:0]           data;
	} ex_dst_t;

	typedef struct packed {
		logic                                   en;
		logic [cpu_isa_pkg::XLEN-1:0]           pc;
	} ex_branch_t;

	// addr is the word address
	typedef struct packed {
		logic                                   en;
		logic                                   we;
		cpu_isa_pkg::mem_size_e                 size;
		logic [cpu_isa_pkg::XLEN-1:2]           addr;
		logic [cpu_isa_pkg::BYTE_LANES-1:0]     sel;
		logic [cpu_isa_pkg::XLEN-1:0]           wdata;
	} ex_mem_t;

endpackage

`default_nettype wire

// File: ex_alu.sv
// execution ALU
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
	input  ex_stage_pkg::ex_op_t            op_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]    rs_data_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]    rt_data_i,
	output logic [cpu_isa_pkg::XLEN-1:0]    result_o,
	output ex_stage_pkg::alu_flags_t        flags_o
);

	logic [cpu_isa_pkg::XLEN-1:0] operand1;
	logic [cpu_isa_pkg::XLEN-1:0] sum;
	logic [cpu_isa_pkg::XLEN-1:0] diff;
	logic [cpu_isa_pkg::XLEN-1:0] adder_result;
	logic [cpu_isa_pkg::XLEN-1:0] logic_result;
	logic [cpu_isa_pkg::XLEN-1:0] comp_result;
	logic                         less_signed;
	logic                         less_unsigned;

	assign operand1      = op_i.alu_imm_en ? op_i.imm : rt_data_i;
	assign sum           = rs_data_i + operand1;
	assign diff          = rs_data_i - operand1;
	assign less_signed   = $signed(rs_data_i) < $signed(operand1);
	assign less_unsigned = rs_data_i < operand1;

	assign adder_result = (op_i.adder_func == cpu_isa_pkg::ADDER_SUB) ? diff : sum;

	always_comb begin
		case (op_i.logic_func)
			cpu_isa_pkg::LOGIC_AND: logic_result = rs_data_i & operand1;
			cpu_isa_pkg::LOGIC_OR:  logic_result = rs_data_i | operand1;
			cpu_isa_pkg::LOGIC_XOR: logic_result = rs_data_i ^ operand1;
			default:                logic_result = ~(rs_data_i | operand1);
		endcase
	end

	assign comp_result = {{(cpu_isa_pkg::XLEN-1){1'b0}},
			(op_i.comp_func == cpu_isa_pkg::COMP_SLTU) ? less_unsigned : less_signed};

	// disabled units contribute zero
	assign result_o = (op_i.adder_en ? adder_result : '0)
			| (op_i.logic_en ? logic_result : '0)
			| (op_i.comp_en ? comp_result : '0);

	// branch flags from rs - operand1, whatever unit is selected
	assign flags_o.zero     = (diff == '0);
	assign flags_o.negative = less_signed;

	always_comb begin
		if (!$isunknown({op_i.adder_en, op_i.logic_en, op_i.comp_en})) begin
			assert ($onehot0({op_i.adder_en, op_i.logic_en, op_i.comp_en}))
				else $error("ex_alu: more than one ALU unit enabled");
		end
	end

endmodule

`default_nettype wire

// File: ex_shifter.sv
// barrel shifter
`timescale 1ns/1ps
`default_nettype none

module ex_shifter (
	input  ex_stage_pkg::ex_op_t            op_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]    rs_data_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]    rt_data_i,
	output logic [cpu_isa_pkg::XLEN-1:0]    result_o
);

	logic [cpu_isa_pkg::SHAMT_W-1:0] sa;
	logic [cpu_isa_pkg::XLEN-1:0]    shifted;

	// immediate shamt or variable shift by rs
	assign sa = op_i.sa_en ? op_i.sa_data : rs_data_i[cpu_isa_pkg::SHAMT_W-1:0];

	always_comb begin
		case (op_i.shift_func)
			cpu_isa_pkg::SHIFT_SLL: shifted = rt_data_i << sa;
			cpu_isa_pkg::SHIFT_SRL: shifted = rt_data_i >> sa;
			cpu_isa_pkg::SHIFT_SRA: shifted = $unsigned($signed(rt_data_i) >>> sa);
			default:                shifted = '0;
		endcase
	end

	assign result_o = op_i.shifter_en ? shifted : '0;

endmodule

`default_nettype wire

// File: ex_result_stage.sv
// execution result stage
// destination merge, branch resolve, store format, output registers
`timescale 1ns/1ps
`default_nettype none

module ex_result_stage (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            interlock_i,
	input  logic                            stall_i,
	input  logic                            endian_i,
	input  ex_stage_pkg::ex_op_t            op_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]    rs_data_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]    rt_data_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]    pc_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]    alu_result_i,
	input  ex_stage_pkg::alu_flags_t        alu_flags_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]    shift_result_i,
	output ex_stage_pkg::ex_dst_t           dst_o,
	output ex_stage_pkg::ex_branch_t        branch_o,
	output ex_stage_pkg::ex_mem_t           mem_o
);

	logic [cpu_isa_pkg::XLEN-1:0]          pc_plus4;
	logic [cpu_isa_pkg::XLEN-1:0]          pc_plus8;
	logic                                  taken;
	logic [1:0]                            byte_lane;
	logic                                  half_lane;
	ex_stage_pkg::ex_dst_t                 dst_d;
	ex_stage_pkg::ex_branch_t              branch_d;
	ex_stage_pkg::ex_mem_t                 mem_d;

	logic                                  dst_en_q;
	logic                                  branch_en_q;
	logic                                  mem_en_q;
	logic                                  mem_we_q;
	logic [cpu_isa_pkg::REG_ADDR_W-1:0]    dst_addr_q;
	logic [cpu_isa_pkg::XLEN-1:0]          dst_data_q;
	logic [cpu_isa_pkg::XLEN-1:0]          branch_pc_q;
	cpu_isa_pkg::mem_size_e                mem_size_q;
	logic [cpu_isa_pkg::XLEN-1:2]          mem_addr_q;
	logic [cpu_isa_pkg::BYTE_LANES-1:0]    mem_sel_q;
	logic [cpu_isa_pkg::XLEN-1:0]          mem_wdata_q;

	assign pc_plus4 = pc_i + 4;
	// link address skips the delay slot
	assign pc_plus8 = pc_i + 8;

	// ------------------------------------------------------------------------
	//  destination
	// ------------------------------------------------------------------------
	always_comb begin
		dst_d.en   = op_i.dst_reg_en & ~stall_i;
		dst_d.addr = op_i.dst_reg_addr;
		dst_d.data = (op_i.dst_src.alu ? alu_result_i : '0)
				| (op_i.dst_src.shifter ? shift_result_i : '0)
				| (op_i.dst_src.pc ? pc_plus8 : '0);
	end

	// ------------------------------------------------------------------------
	//  branch
	// ------------------------------------------------------------------------
	always_comb begin
		case (op_i.branch_func)
			cpu_isa_pkg::BR_JALR,
			cpu_isa_pkg::BR_J,
			cpu_isa_pkg::BR_JAL:  taken = 1'b1;
			cpu_isa_pkg::BR_BEQ:  taken = alu_flags_i.zero;
			cpu_isa_pkg::BR_BNE:  taken = ~alu_flags_i.zero;
			cpu_isa_pkg::BR_BLEZ: taken = alu_flags_i.negative | alu_flags_i.zero;
			cpu_isa_pkg::BR_BGTZ: taken = ~alu_flags_i.negative & ~alu_flags_i.zero;
			cpu_isa_pkg::BR_BLTZ: taken = alu_flags_i.negative;
			cpu_isa_pkg::BR_BGEZ: taken = ~alu_flags_i.negative;
			default:              taken = 1'b0;
		endcase
	end

	always_comb begin
		branch_d.en = op_i.branch_en & ~stall_i & taken;
		branch_d.pc = (op_i.index_en ? {pc_i[cpu_isa_pkg::XLEN-1 -: 4], op_i.index, 2'b00} : '0)
				| (op_i.imm_en ? pc_plus4 + (op_i.imm << 2) : '0)
				| (op_i.rs_en ? rs_data_i : '0);
	end

	// ------------------------------------------------------------------------
	//  store lanes
	// ------------------------------------------------------------------------
	assign byte_lane = alu_result_i[1:0] ^ {2{endian_i}};
	assign half_lane = alu_result_i[1] ^ endian_i;

	always_comb begin
		mem_d.en   = op_i.mem_en & ~stall_i;
		mem_d.we   = op_i.mem_en & op_i.mem_we;
		mem_d.size = op_i.mem_size;
		mem_d.addr = alu_result_i[cpu_isa_pkg::XLEN-1:2];
		case (op_i.mem_size)
			cpu_isa_pkg::SIZE_BYTE: begin
				mem_d.sel   = {{(cpu_isa_pkg::BYTE_LANES-1){1'b0}}, 1'b1} << byte_lane;
				mem_d.wdata = {(cpu_isa_pkg::BYTE_LANES){rt_data_i[7:0]}};
			end
			cpu_isa_pkg::SIZE_HALF: begin
				mem_d.sel   = half_lane ? 4'b1100 : 4'b0011;
				mem_d.wdata = {(cpu_isa_pkg::BYTE_LANES/2){rt_data_i[15:0]}};
			end
			default: begin
				mem_d.sel   = '1;
				mem_d.wdata = rt_data_i;
			end
		endcase
		if (!op_i.mem_en) begin
			mem_d.sel = '0;
		end
	end

	// ------------------------------------------------------------------------
	//  output registers, frozen by interlock
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			dst_en_q    <= 1'b0;
			branch_en_q <= 1'b0;
			mem_en_q    <= 1'b0;
			mem_we_q    <= 1'b0;
		end
		else if (!interlock_i) begin
			dst_en_q    <= dst_d.en;
			branch_en_q <= branch_d.en;
			mem_en_q    <= mem_d.en;
			mem_we_q    <= mem_d.we;
		end
	end

	always_ff @(posedge clk) begin
		if (!interlock_i) begin
			dst_addr_q  <= dst_d.addr;
			dst_data_q  <= dst_d.data;
			branch_pc_q <= branch_d.pc;
			mem_size_q  <= mem_d.size;
			mem_addr_q  <= mem_d.addr;
			mem_sel_q   <= mem_d.sel;
			mem_wdata_q <= mem_d.wdata;
		end
	end

	assign dst_o    = '{en: dst_en_q, addr: dst_addr_q, data: dst_data_q};
	assign branch_o = '{en: branch_en_q, pc: branch_pc_q};
	assign mem_o    = '{en: mem_en_q, we: mem_we_q, size: mem_size_q, addr: mem_addr_q,
			sel: mem_sel_q, wdata: mem_wdata_q};

	a_dst_src_onehot: assert property (@(posedge clk) disable iff (reset)
		op_i.dst_reg_en |-> $onehot0({op_i.dst_src.alu, op_i.dst_src.shifter, op_i.dst_src.pc}));

	// a live access must touch at least one lane
	a_mem_sel: assert property (@(posedge clk) disable iff (reset)
		mem_o.en |-> (mem_o.sel != '0));

endmodule

`default_nettype wire

// File: ex_unit.sv
// execution unit top
`timescale 1ns/1ps
`default_nettype none

module ex_unit (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            interlock_i,
	input  logic                            stall_i,
	input  logic                            endian_i,
	input  ex_stage_pkg::ex_op_t            op_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]    rs_data_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]    rt_data_i,
	input  logic [cpu_isa_pkg::XLEN-1:0]    pc_i,
	output ex_stage_pkg::ex_dst_t           dst_o,
	output ex_stage_pkg::ex_branch_t        branch_o,
	output ex_stage_pkg::ex_mem_t           mem_o
);

	logic [cpu_isa_pkg::XLEN-1:0] alu_result;
	ex_stage_pkg::alu_flags_t     alu_flags;
	logic [cpu_isa_pkg::XLEN-1:0] shift_result;

	// alu and shifter run side by side
	ex_alu i_alu (
		.op_i           (op_i),
		.rs_data_i      (rs_data_i),
		.rt_data_i      (rt_data_i),
		.result_o       (alu_result),
		.flags_o        (alu_flags)
	);

	ex_shifter i_shifter (
		.op_i           (op_i),
		.rs_data_i      (rs_data_i),
		.rt_data_i      (rt_data_i),
		.result_o       (shift_result)
	);

	ex_result_stage i_result (
		.clk            (clk),
		.reset          (reset),
		.interlock_i    (interlock_i),
		.stall_i        (stall_i),
		.endian_i       (endian_i),
		.op_i           (op_i),
		.rs_data_i      (rs_data_i),
		.rt_data_i      (rt_data_i),
		.pc_i           (pc_i),
		.alu_result_i   (alu_result),
		.alu_flags_i    (alu_flags),
		.shift_result_i (shift_result),
		.dst_o          (dst_o),
		.branch_o       (branch_o),
		.mem_o          (mem_o)
	);

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
// testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_o,
	output logic reset_o
);

	localparam int HALF_PERIOD  = 2;
	localparam int RESET_CYCLES = 10;

	initial begin
		clk_o = 1'b0;
		forever #HALF_PERIOD clk_o = ~clk_o;
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		reset_o = 1'b0;
	end

endmodule

`default_nettype wire

// File: tb_ex_unit.sv
// execution unit testbench
`timescale 1ns/1ps
`default_nettype none

module tb_ex_unit;

	localparam int XLEN         = cpu_isa_pkg::XLEN;
	localparam int RESET_CYCLES = 10;
	localparam int N_ALU        = 200;
	localparam int N_SHIFT      = 120;
	localparam int N_PC         = 20;
	localparam int N_BRANCH     = 9 * 3 * 5;
	localparam int N_MEM        = 3 * 2 * 8;
	localparam int N_HOLD       = 1 + 6 + 12;
	localparam int N_DRAIN      = 4;
	localparam int TOTAL_CYCLES = RESET_CYCLES + N_ALU + N_SHIFT + N_PC + N_BRANCH
			+ N_MEM + N_HOLD + N_DRAIN;
	localparam int CYCLE_LIMIT  = 2 * TOTAL_CYCLES;

	typedef struct packed {
		ex_stage_pkg::ex_dst_t    dst;
		ex_stage_pkg::ex_branch_t branch;
		ex_stage_pkg::ex_mem_t    mem;
	} ex_result_t;

	logic                     clk;
	logic                     reset;
	logic                     interlock;
	logic                     stall;
	logic                     endian;
	ex_stage_pkg::ex_op_t     op;
	logic [XLEN-1:0]          rs_data;
	logic [XLEN-1:0]          rt_data;
	logic [XLEN-1:0]          pc;
	ex_stage_pkg::ex_dst_t    dst;
	ex_stage_pkg::ex_branch_t branch;
	ex_stage_pkg::ex_mem_t    mem;

	integer     seed = 32'h86a5_aee8;
	int         cycle_count = 0;
	ex_result_t expected;
	logic       expected_valid = 1'b0;

	tb_clock_gen i_clock_gen (
		.clk_o   (clk),
		.reset_o (reset)
	);

	ex_unit i_dut (
		.clk         (clk),
		.reset       (reset),
		.interlock_i (interlock),
		.stall_i     (stall),
		.endian_i    (endian),
		.op_i        (op),
		.rs_data_i   (rs_data),
		.rt_data_i   (rt_data),
		.pc_i        (pc),
		.dst_o       (dst),
		.branch_o    (branch),
		.mem_o       (mem)
	);

	// ------------------------------------------------------------------------
	//  reference model
	// ------------------------------------------------------------------------
	function automatic ex_result_t predict_outputs(input ex_stage_pkg::ex_op_t o,
			input logic [XLEN-1:0] rs, input logic [XLEN-1:0] rt,
			input logic [XLEN-1:0] pc_in, input logic big_end, input logic stall_in);
		ex_result_t      res;
		logic [XLEN-1:0] op1;
		logic [XLEN-1:0] alu;
		logic [XLEN-1:0] shifted;
		logic [4:0]      sa;
		logic            zero;
		logic            neg;
		logic            less;
		logic            taken;
		logic [1:0]      lane;
		res  = '0;
		op1  = o.alu_imm_en ? o.imm : rt;
		zero = ((rs - op1) == 32'h0);
		neg  = $signed(rs) < $signed(op1);
		alu  = 32'h0;
		if (o.adder_en) begin
			alu |= (o.adder_func == cpu_isa_pkg::ADDER_SUB) ? rs - op1 : rs + op1;
		end
		if (o.logic_en) begin
			case (o.logic_func)
				cpu_isa_pkg::LOGIC_AND: alu |= rs & op1;
				cpu_isa_pkg::LOGIC_OR:  alu |= rs | op1;
				cpu_isa_pkg::LOGIC_XOR: alu |= rs ^ op1;
				default:                alu |= ~(rs | op1);
			endcase
		end
		if (o.comp_en) begin
			less = (o.comp_func == cpu_isa_pkg::COMP_SLTU) ? (rs < op1) : neg;
			alu |= {31'b0, less};
		end
		sa = o.sa_en ? o.sa_data : rs[4:0];
		case (o.shift_func)
			cpu_isa_pkg::SHIFT_SLL: shifted = rt << sa;
			cpu_isa_pkg::SHIFT_SRL: shifted = rt >> sa;
			cpu_isa_pkg::SHIFT_SRA: shifted = (rt >> sa) | ({32{rt[31]}} & ~(32'hffff_ffff >> sa));
			default:                shifted = 32'h0;
		endcase
		if (!o.shifter_en) begin
			shifted = 32'h0;
		end
		res.dst.en   = o.dst_reg_en & ~stall_in;
		res.dst.addr = o.dst_reg_addr;
		res.dst.data = (o.dst_src.alu ? alu : 32'h0) | (o.dst_src.shifter ? shifted : 32'h0)
				| (o.dst_src.pc ? pc_in + 32'd8 : 32'h0);
		case (o.branch_func)
			cpu_isa_pkg::BR_JALR, cpu_isa_pkg::BR_J, cpu_isa_pkg::BR_JAL: taken = 1'b1;
			cpu_isa_pkg::BR_BEQ:  taken = zero;
			cpu_isa_pkg::BR_BNE:  taken = ~zero;
			cpu_isa_pkg::BR_BLEZ: taken = neg | zero;
			cpu_isa_pkg::BR_BGTZ: taken = ~(neg | zero);
			cpu_isa_pkg::BR_BLTZ: taken = neg;
			cpu_isa_pkg::BR_BGEZ: taken = ~neg;
			default:              taken = 1'b0;
		endcase
		res.branch.en = o.branch_en & taken & ~stall_in;
		if (o.index_en) begin
			res.branch.pc |= {pc_in[XLEN-1:XLEN-4], o.index, 2'b00};
		end
		if (o.imm_en) begin
			res.branch.pc |= pc_in + 32'd4 + {o.imm[XLEN-3:0], 2'b00};
		end
		if (o.rs_en) begin
			res.branch.pc |= rs;
		end
		res.mem.en   = o.mem_en & ~stall_in;
		res.mem.we   = o.mem_en & o.mem_we;
		res.mem.size = o.mem_size;
		res.mem.addr = alu[XLEN-1:2];
		case (o.mem_size)
			cpu_isa_pkg::SIZE_BYTE: begin
				lane = big_end ? ~alu[1:0] : alu[1:0];
				res.mem.sel   = 4'b0001 << lane;
				res.mem.wdata = {4{rt[7:0]}};
			end
			cpu_isa_pkg::SIZE_HALF: begin
				res.mem.sel   = (alu[1] ^ big_end) ? 4'b1100 : 4'b0011;
				res.mem.wdata = {2{rt[15:0]}};
			end
			default: begin
				res.mem.sel   = 4'b1111;
				res.mem.wdata = rt;
			end
		endcase
		if (!o.mem_en) begin
			res.mem.sel = 4'b0000;
		end
		return res;
	endfunction

	// ------------------------------------------------------------------------
	//  checks
	// ------------------------------------------------------------------------
	task automatic stop_with_failure();
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_dst(input string name, input ex_stage_pkg::ex_dst_t got,
			input ex_stage_pkg::ex_dst_t exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_branch(input string name, input ex_stage_pkg::ex_branch_t got,
			input ex_stage_pkg::ex_branch_t exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_mem(input string name, input ex_stage_pkg::ex_mem_t got,
			input ex_stage_pkg::ex_mem_t exp);
		if (got !== exp) begin
			$display("FAILED %s: got %h expected %h", name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic expect_low(input string name, input logic got);
		if (got !== 1'b0) begin
			$display("FAILED %s: got %h expected 0", name, got);
			stop_with_failure();
		end
	endtask

	// capture on the rising edge, compare on the next falling edge
	always begin
		@(posedge clk);
		if (reset) begin
			expected_valid = 1'b0;
		end
		else if (!interlock) begin
			expected       = predict_outputs(op, rs_data, rt_data, pc, endian, stall);
			expected_valid = 1'b1;
		end
		@(negedge clk);
		if (expected_valid) begin
			check_dst("dst_o", dst, expected.dst);
			check_branch("branch_o", branch, expected.branch);
			check_mem("mem_o", mem, expected.mem);
		end
	end

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the tests did not finish", cycle_count);
			stop_with_failure();
		end
	end

	// ------------------------------------------------------------------------
	//  stimulus
	// ------------------------------------------------------------------------
	function automatic logic [XLEN-1:0] next_random();
		return $random(seed);
	endfunction

	function automatic logic [XLEN-1:0] random_pc();
		logic [XLEN-1:0] r;
		r = next_random();
		return {r[XLEN-1:2], 2'b00};
	endfunction

	function automatic ex_stage_pkg::ex_op_t random_alu_op();
		ex_stage_pkg::ex_op_t o;
		logic [XLEN-1:0]      r;
		o = '0;
		r = next_random();
		o.adder_en     = (r[1:0] == 2'd0);
		o.logic_en     = (r[1:0] == 2'd1);
		o.comp_en      = r[1];
		o.adder_func   = r[2] ? cpu_isa_pkg::ADDER_SUB : cpu_isa_pkg::ADDER_ADD;
		o.logic_func   = cpu_isa_pkg::logic_func_e'(r[4:3]);
		o.comp_func    = cpu_isa_pkg::comp_func_e'(r[5]);
		o.alu_imm_en   = r[6];
		o.imm          = next_random();
		o.dst_reg_en   = 1'b1;
		o.dst_reg_addr = r[11:7];
		o.dst_src.alu  = 1'b1;
		return o;
	endfunction

	function automatic ex_stage_pkg::ex_op_t random_shift_op();
		ex_stage_pkg::ex_op_t o;
		logic [XLEN-1:0]      r;
		o = '0;
		r = next_random();
		o.shifter_en      = 1'b1;
		o.shift_func      = (r[1:0] == 2'd0) ? cpu_isa_pkg::SHIFT_SLL
				: (r[1:0] == 2'd1) ? cpu_isa_pkg::SHIFT_SRL : cpu_isa_pkg::SHIFT_SRA;
		o.sa_en           = r[2];
		o.sa_data         = r[7:3];
		o.dst_reg_en      = 1'b1;
		o.dst_reg_addr    = r[12:8];
		o.dst_src.shifter = 1'b1;
		return o;
	endfunction

	function automatic cpu_isa_pkg::branch_func_e branch_func_at(input int i);
		case (i)
			0:       return cpu_isa_pkg::BR_JALR;
			1:       return cpu_isa_pkg::BR_J;
			2:       return cpu_isa_pkg::BR_JAL;
			3:       return cpu_isa_pkg::BR_BEQ;
			4:       return cpu_isa_pkg::BR_BNE;
			5:       return cpu_isa_pkg::BR_BLEZ;
			6:       return cpu_isa_pkg::BR_BGTZ;
			7:       return cpu_isa_pkg::BR_BLTZ;
			default: return cpu_isa_pkg::BR_BGEZ;
		endcase
	endfunction

	task automatic drive_inputs(input ex_stage_pkg::ex_op_t o, input logic [XLEN-1:0] rs,
			input logic [XLEN-1:0] rt, input logic [XLEN-1:0] pc_in, input logic big_end,
			input logic stall_in, input logic hold);
		@(negedge clk);
		op        = o;
		rs_data   = rs;
		rt_data   = rt;
		pc        = pc_in;
		endian    = big_end;
		stall     = stall_in;
		interlock = hold;
	endtask

	initial begin
		ex_stage_pkg::ex_op_t o;
		logic [XLEN-1:0]      r;
		logic [XLEN-1:0]      a;
		logic [XLEN-1:0]      b;
		op        = '0;
		rs_data   = '0;
		rt_data   = '0;
		pc        = '0;
		endian    = 1'b0;
		stall     = 1'b0;
		interlock = 1'b0;
		wait (reset == 1'b0);
		expect_low("dst_o.en", dst.en);
		expect_low("branch_o.en", branch.en);
		expect_low("mem_o.en", mem.en);
		expect_low("mem_o.we", mem.we);

		for (int i = 0; i < N_ALU; i++) begin
			r = next_random();
			drive_inputs(random_alu_op(), next_random(), next_random(), random_pc(), r[0],
					1'b0, 1'b0);
		end
		for (int i = 0; i < N_SHIFT; i++) begin
			drive_inputs(random_shift_op(), next_random(), next_random(), random_pc(), 1'b0,
					1'b0, 1'b0);
		end
		for (int i = 0; i < N_PC; i++) begin
			o = '0;
			o.dst_reg_en   = 1'b1;
			o.dst_reg_addr = 5'd31;
			o.dst_src.pc   = 1'b1;
			drive_inputs(o, next_random(), next_random(), random_pc(), 1'b0, 1'b0, 1'b0);
		end

		// each func, each target form, operands on both sides of the condition
		for (int f = 0; f < 9; f++) begin
			for (int t = 0; t < 3; t++) begin
				for (int c = 0; c < 5; c++) begin
					o = '0;
					r = next_random();
					o.branch_en   = 1'b1;
					o.branch_func = branch_func_at(f);
					o.index       = r[25:0];
					o.imm         = {{16{r[15]}}, r[15:0]};
					o.index_en    = (t == 0);
					o.imm_en      = (t == 1);
					o.rs_en       = (t == 2);
					if (o.branch_func == cpu_isa_pkg::BR_JAL) begin
						o.dst_reg_en   = 1'b1;
						o.dst_reg_addr = 5'd31;
						o.dst_src.pc   = 1'b1;
					end
					a = next_random();
					case (c)
						0: b = a;
						1: begin
							a = {1'b1, a[30:0]};
							b = 32'h0;
						end
						2: begin
							a = {1'b0, a[30:1], 1'b1};
							b = 32'h0;
						end
						3: begin
							a = 32'h0;
							b = 32'h0;
						end
						default: b = next_random();
					endcase
					drive_inputs(o, a, b, random_pc(), 1'b0, 1'b0, 1'b0);
				end
			end
		end

		// stores on every lane in both endians, loads for the upper half of k
		for (int s = 0; s < 3; s++) begin
			for (int e = 0; e < 2; e++) begin
				for (int k = 0; k < 8; k++) begin
					o = '0;
					r = next_random();
					a = next_random();
					o.adder_en   = 1'b1;
					o.alu_imm_en = 1'b1;
					o.imm        = {{16{r[15]}}, r[15:0]};
					o.mem_en     = 1'b1;
					o.mem_we     = (k < 4);
					o.mem_size   = cpu_isa_pkg::mem_size_e'(2'(s));
					a = {a[XLEN-1:2], 2'(k)};
					drive_inputs(o, a - o.imm, next_random(), random_pc(), 1'(e), 1'b0, 1'b0);
				end
			end
		end

		// outputs hold while interlocked, inputs keep moving
		drive_inputs(random_alu_op(), next_random(), next_random(), random_pc(), 1'b0,
				1'b0, 1'b0);
		for (int i = 0; i < 6; i++) begin
			drive_inputs(random_shift_op(), next_random(), next_random(), random_pc(), 1'b1,
					1'b0, 1'b1);
		end
		// dst, branch and store all requested, none may go out
		for (int i = 0; i < 12; i++) begin
			o = '0;
			r = next_random();
			a = next_random();
			o.adder_en     = 1'b1;
			o.alu_imm_en   = 1'b1;
			o.imm          = {{16{r[15]}}, r[15:0]};
			o.dst_reg_en   = 1'b1;
			o.dst_reg_addr = r[20:16];
			o.dst_src.alu  = 1'b1;
			o.branch_en    = 1'b1;
			o.branch_func  = cpu_isa_pkg::BR_J;
			o.index        = a[cpu_isa_pkg::INDEX_W-1:0];
			o.index_en     = 1'b1;
			o.mem_en       = 1'b1;
			o.mem_we       = 1'b1;
			o.mem_size     = cpu_isa_pkg::SIZE_WORD;
			drive_inputs(o, next_random(), next_random(), random_pc(), r[21], 1'b1, 1'b0);
		end

		for (int i = 0; i < N_DRAIN - 1; i++) begin
			drive_inputs('0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0);
		end
		@(negedge clk);
		@(posedge clk);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
cpu_isa_pkg.sv
ex_stage_pkg.sv
ex_alu.sv
ex_shifter.sv
ex_result_stage.sv
ex_unit.sv
tb_clock_gen.sv
tb_ex_unit.sv

// File: run_sim.sh
#!/bin/sh
# build and run the execution unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sim.f --top-module tb_ex_unit -o tb_ex_unit
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

output=$(./obj_dir/tb_ex_unit)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -q '^ALL TESTS PASSED$'; then
	exit 0
fi
echo "pass message not found"
exit 1
